//--- list.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_if.sv
rtl/exu_decode.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_commit.sv
rtl/exu_top.sv
test/exu_asserts.sv
test/exu_tb.sv

//--- rtl/exu_alu.sv
// Operand select with write-back bypass, ALU and result register
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_alu import exu_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  exu_dec_if.dst                  i_dec,
  output logic [`EXU_RFIDX_W-1:0] o_rs1idx,
  output logic [`EXU_RFIDX_W-1:0] o_rs2idx,
  input  logic [`EXU_XLEN-1:0]    i_rs1dat,
  input  logic [`EXU_XLEN-1:0]    i_rs2dat,
  exu_wbck_if.src                 o_wbck
);

  logic                 byp_ok;
  logic                 byp_rs1;
  logic                 byp_rs2;
  logic [`EXU_XLEN-1:0] src1;
  logic [`EXU_XLEN-1:0] src2;
  logic [`EXU_XLEN-1:0] op_a;
  logic [`EXU_XLEN-1:0] op_b;
  logic [4:0]           shamt;
  logic [`EXU_XLEN-1:0] alu_res;

  // Register file read indices
  assign o_rs1idx = i_dec.rs1idx;
  assign o_rs2idx = i_dec.rs2idx;

  //////////////////////////////
  // Bypass
  // The write-back register is written to the register file at the same edge
  // that captures the next result, so the instruction right behind it must
  // take the value from here
  assign byp_ok  = o_wbck.valid & ~o_wbck.ilegl & o_wbck.rdwen & (o_wbck.rdidx != '0);
  assign byp_rs1 = byp_ok & (o_wbck.rdidx == i_dec.rs1idx);
  assign byp_rs2 = byp_ok & (o_wbck.rdidx == i_dec.rs2idx);

  assign src1 = byp_rs1 ? o_wbck.wdat : i_rs1dat;
  assign src2 = byp_rs2 ? o_wbck.wdat : i_rs2dat;

  //////////////////////////////
  // Operands
  always_comb begin
    if (i_dec.use_pc) begin
      op_a = i_dec.pc;            // AUIPC
    end else if (i_dec.aluop == PASS_B) begin
      op_a = '0;                  // LUI
    end else begin
      op_a = src1;
    end
  end

  assign op_b  = i_dec.use_imm ? i_dec.imm : src2;
  assign shamt = op_b[4:0];

  // Operation
  always_comb begin
    case (i_dec.aluop)
      ADD:     alu_res = op_a + op_b;
      SUB:     alu_res = op_a - op_b;
      SLL:     alu_res = op_a << shamt;
      SLT:     alu_res = {{(`EXU_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      SLTU:    alu_res = {{(`EXU_XLEN-1){1'b0}}, (op_a < op_b)};
      XOR:     alu_res = op_a ^ op_b;
      SRL:     alu_res = op_a >> shamt;
      SRA:     alu_res = $unsigned($signed(op_a) >>> shamt);
      OR:      alu_res = op_a | op_b;
      AND:     alu_res = op_a & op_b;
      default: alu_res = op_b;   // PASS_B
    endcase
  end

  //////////////////////////////
  // Result register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_wbck.valid <= 1'b0;
    end else begin
      o_wbck.valid <= i_dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    o_wbck.rdidx <= i_dec.rdidx;
    o_wbck.rdwen <= i_dec.rdwen;
    o_wbck.wdat  <= alu_res;
    o_wbck.ilegl <= i_dec.ilegl;
  end

endmodule

//--- rtl/exu_commit.sv
// Commit side: register-file write, retire counter, trap pulse and activity
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_commit (
  input  logic                      clk,
  input  logic                      i_reset,
  exu_wbck_if.dst                   i_wbck,
  output logic                      o_rf_wen,
  output logic [`EXU_RFIDX_W-1:0]   o_rf_widx,
  output logic [`EXU_XLEN-1:0]      o_rf_wdat,
  output logic                      o_wbck_ena,
  output logic [`EXU_RFIDX_W-1:0]   o_wbck_rdidx,
  output logic [`EXU_XLEN-1:0]      o_wbck_wdat,
  output logic                      o_commit_trap,
  output logic [`EXU_INSTRET_W-1:0] o_instret,
  input  logic                      i_dec_valid,
  output logic                      o_active
);

  logic cmt_legal;

  assign cmt_legal = i_wbck.valid & ~i_wbck.ilegl;

  // Writes to x0 are dropped here
  assign o_rf_wen  = cmt_legal & i_wbck.rdwen & (i_wbck.rdidx != '0);
  assign o_rf_widx = i_wbck.rdidx;
  assign o_rf_wdat = i_wbck.wdat;

  // Same write, seen from outside
  assign o_wbck_ena   = o_rf_wen;
  assign o_wbck_rdidx = i_wbck.rdidx;
  assign o_wbck_wdat  = i_wbck.wdat;

  assign o_commit_trap = i_wbck.valid & i_wbck.ilegl;  // One cycle per illegal op

  //////////////////////////////
  // Retire counter
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_instret <= '0;
    end else if (cmt_legal) begin
      o_instret <= o_instret + 1'b1;
    end
  end

  // Either stage busy
  assign o_active = i_dec_valid | i_wbck.valid;

endmodule

//--- rtl/exu_consts.svh
// Width and size macros for the integer execution stage
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// Datapath widths
`define EXU_XLEN        32
`define EXU_PC_W        32
`define EXU_INSTR_W     32

// Integer register file
`define EXU_RFIDX_W     5
`define EXU_RF_NUM      32

// Retired-instruction counter
`define EXU_INSTRET_W   32

`endif

//--- rtl/exu_decode.sv
// Instruction decode and the registered decode bundle
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_decode import exu_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  logic [`EXU_INSTR_W-1:0] i_instr,
  input  logic [`EXU_PC_W-1:0]    i_pc,
  exu_dec_if.src                  o_dec
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic                 f7_zero;
  logic                 f7_alt;     // 0100000, SUB and SRA(I)
  logic [`EXU_XLEN-1:0] imm_i;
  logic [`EXU_XLEN-1:0] imm_u;
  exu_aluop_e           f3_op;
  exu_aluop_e           dec_aluop;
  logic [`EXU_XLEN-1:0] dec_imm;
  logic                 dec_use_imm;
  logic                 dec_use_pc;
  logic                 dec_ilegl;

  //////////////////////////////
  // Field split
  assign opcode  = i_instr[6:0];
  assign funct3  = i_instr[14:12];
  assign funct7  = i_instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i = {{(`EXU_XLEN-12){i_instr[31]}}, i_instr[31:20]}; // Sign extended
  assign imm_u = {i_instr[31:12], 12'b0};

  // Shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  f3_op = ADD;
      3'b001:  f3_op = SLL;
      3'b010:  f3_op = SLT;
      3'b011:  f3_op = SLTU;
      3'b100:  f3_op = XOR;
      3'b101:  f3_op = f7_alt ? SRA : SRL;
      3'b110:  f3_op = OR;
      default: f3_op = AND;
    endcase
  end

  //////////////////////////////
  // Opcode decode
  always_comb begin
    dec_aluop   = f3_op;
    dec_imm     = imm_i;
    dec_use_imm = 1'b0;
    dec_use_pc  = 1'b0;
    dec_ilegl   = 1'b0;
    case (opcode)
      OPC_OP: begin
        if ((funct3 == 3'b000) && f7_alt) begin
          dec_aluop = SUB;
        end
        // Alternate funct7 only with ADD/SUB and SRL/SRA
        dec_ilegl = ~(f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101))));
      end
      OPC_OP_IMM: begin
        dec_use_imm = 1'b1;
        if (funct3 == 3'b001) begin
          dec_ilegl = ~f7_zero;            // SLLI
        end else if (funct3 == 3'b101) begin
          dec_ilegl = ~(f7_zero | f7_alt); // SRLI or SRAI
        end
      end
      OPC_LUI: begin
        dec_aluop   = PASS_B;
        dec_imm     = imm_u;
        dec_use_imm = 1'b1;
      end
      OPC_AUIPC: begin
        dec_aluop   = ADD;
        dec_imm     = imm_u;
        dec_use_imm = 1'b1;
        dec_use_pc  = 1'b1;
      end
      default: dec_ilegl = 1'b1;
    endcase
  end

  //////////////////////////////
  // Bundle register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_dec.valid <= 1'b0;
    end else begin
      o_dec.valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_dec.aluop   <= dec_aluop;
    o_dec.rs1idx  <= i_instr[19:15];
    o_dec.rs2idx  <= i_instr[24:20];
    o_dec.rdidx   <= i_instr[11:7];
    o_dec.rdwen   <= ~dec_ilegl;  // Every legal op writes rd
    o_dec.imm     <= dec_imm;
    o_dec.use_imm <= dec_use_imm;
    o_dec.pc      <= i_pc;
    o_dec.use_pc  <= dec_use_pc;
    o_dec.ilegl   <= dec_ilegl;
  end

endmodule

//--- rtl/exu_if.sv
// Decode-to-ALU and ALU-to-commit interfaces with their modports
`timescale 1ns/1ps
`include "exu_consts.svh"

//////////////////////////////
// Decoded instruction bundle
interface exu_dec_if import exu_pkg::*; ();
  logic                    valid;   // One instruction per valid cycle
  exu_aluop_e              aluop;
  logic [`EXU_RFIDX_W-1:0] rs1idx;
  logic [`EXU_RFIDX_W-1:0] rs2idx;
  logic [`EXU_RFIDX_W-1:0] rdidx;
  logic                    rdwen;
  logic [`EXU_XLEN-1:0]    imm;
  logic                    use_imm; // Operand B from imm
  logic [`EXU_PC_W-1:0]    pc;
  logic                    use_pc;  // Operand A from pc
  logic                    ilegl;

  modport src (
    output valid, aluop, rs1idx, rs2idx, rdidx, rdwen,
    output imm, use_imm, pc, use_pc, ilegl
  );

  modport dst (
    input valid, aluop, rs1idx, rs2idx, rdidx, rdwen,
    input imm, use_imm, pc, use_pc, ilegl
  );
endinterface

//////////////////////////////
// ALU result towards commit
interface exu_wbck_if ();
  logic                    valid;
  logic [`EXU_RFIDX_W-1:0] rdidx;
  logic                    rdwen;
  logic [`EXU_XLEN-1:0]    wdat;
  logic                    ilegl;

  // The ALU also reads these back for its bypass
  modport src (output valid, rdidx, rdwen, wdat, ilegl);

  modport dst (input valid, rdidx, rdwen, wdat, ilegl);
endinterface

//--- rtl/exu_pkg.sv
// Package with the major-opcode and ALU-operation enums

package exu_pkg;

  // Major opcodes handled by this stage, everything else is illegal
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register ALU
    OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } exu_opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10  // LUI only
  } exu_aluop_e;

endpackage

//--- rtl/exu_regfile.sv
// Integer register file, two asynchronous reads and one write
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_regfile (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic [`EXU_RFIDX_W-1:0] i_rd1idx,
  input  logic [`EXU_RFIDX_W-1:0] i_rd2idx,
  output logic [`EXU_XLEN-1:0]    o_rd1dat,
  output logic [`EXU_XLEN-1:0]    o_rd2dat,
  input  logic                    i_wen,
  input  logic [`EXU_RFIDX_W-1:0] i_widx,
  input  logic [`EXU_XLEN-1:0]    i_wdat
);

  // x0 has no storage
  logic [`EXU_XLEN-1:0] rf_r [1:`EXU_RF_NUM-1];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 1; i < `EXU_RF_NUM; i++) begin
        rf_r[i] <= '0;
      end
    end else if (i_wen && (i_widx != '0)) begin
      rf_r[i_widx] <= i_wdat;
    end
  end

  // Read ports
  assign o_rd1dat = (i_rd1idx == '0) ? '0 : rf_r[i_rd1idx];
  assign o_rd2dat = (i_rd2idx == '0) ? '0 : rf_r[i_rd2idx];

endmodule

//--- rtl/exu_top.sv
// Top level of the execution stage: decode, ALU, commit and register file
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_top (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic [`EXU_INSTR_W-1:0]   i_instr,
  input  logic [`EXU_PC_W-1:0]      i_pc,
  output logic                      o_wbck_ena,
  output logic [`EXU_RFIDX_W-1:0]   o_wbck_rdidx,
  output logic [`EXU_XLEN-1:0]      o_wbck_wdat,
  output logic                      o_commit_trap,
  output logic [`EXU_INSTRET_W-1:0] o_instret,
  output logic                      o_active
);

  logic [`EXU_RFIDX_W-1:0] rf_rs1idx;
  logic [`EXU_RFIDX_W-1:0] rf_rs2idx;
  logic [`EXU_XLEN-1:0]    rf_rs1dat;
  logic [`EXU_XLEN-1:0]    rf_rs2dat;
  logic                    rf_wen;
  logic [`EXU_RFIDX_W-1:0] rf_widx;
  logic [`EXU_XLEN-1:0]    rf_wdat;

  exu_dec_if  dec_bus ();
  exu_wbck_if wbck_bus ();

  //////////////////////////////
  // Stages
  exu_decode u_decode (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .i_pc    (i_pc),
    .o_dec   (dec_bus.src)
  );

  exu_regfile u_regfile (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_rd1idx (rf_rs1idx),
    .i_rd2idx (rf_rs2idx),
    .o_rd1dat (rf_rs1dat),
    .o_rd2dat (rf_rs2dat),
    .i_wen    (rf_wen),
    .i_widx   (rf_widx),
    .i_wdat   (rf_wdat)
  );

  exu_alu u_alu (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_dec    (dec_bus.dst),
    .o_rs1idx (rf_rs1idx),
    .o_rs2idx (rf_rs2idx),
    .i_rs1dat (rf_rs1dat),
    .i_rs2dat (rf_rs2dat),
    .o_wbck   (wbck_bus.src)
  );

  exu_commit u_commit (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_wbck        (wbck_bus.dst),
    .o_rf_wen      (rf_wen),
    .o_rf_widx     (rf_widx),
    .o_rf_wdat     (rf_wdat),
    .o_wbck_ena    (o_wbck_ena),
    .o_wbck_rdidx  (o_wbck_rdidx),
    .o_wbck_wdat   (o_wbck_wdat),
    .o_commit_trap (o_commit_trap),
    .o_instret     (o_instret),
    .i_dec_valid   (dec_bus.valid),  // Decode stage occupancy
    .o_active      (o_active)
  );

endmodule

//--- test/exu_asserts.sv
// Concurrent assertions on the execution stage top-level outputs
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_asserts (
  input logic                      clk,
  input logic                      i_reset,
  input logic                      i_valid,
  input logic                      i_wbck_ena,
  input logic [`EXU_RFIDX_W-1:0]   i_wbck_rdidx,
  input logic                      i_commit_trap,
  input logic [`EXU_INSTRET_W-1:0] i_instret,
  input logic                      i_active
);

  //////////////////////////////
  // Output exclusivity
  wbck_trap_excl: assert property (@(posedge clk) disable iff (i_reset)
    !(i_wbck_ena && i_commit_trap))
    else $error("Write-back and trap high in the same cycle");

  // x0 never shows up as a write
  wbck_not_x0: assert property (@(posedge clk) disable iff (i_reset)
    i_wbck_ena |-> (i_wbck_rdidx != '0))
    else $error("Write-back reported for x0");

  //////////////////////////////
  // Occupancy
  // Decode stage then ALU stage hold the instruction
  valid_active: assert property (@(posedge clk) disable iff (i_reset)
    i_valid |=> i_active ##1 i_active)
    else $error("Accepted instruction not seen as activity");

  // Trap or retire two cycles after acceptance, never both
  valid_done: assert property (@(posedge clk) disable iff (i_reset)
    i_valid |-> ##3 ((i_instret != $past(i_instret)) ^ $past(i_commit_trap)))
    else $error("Accepted instruction neither trapped nor retired on time");

endmodule

//--- test/exu_tb.sv
// Testbench for the execution stage with clock, stimulus, reference model and checker
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;

  localparam logic [6:0] OPC_R   = 7'b0110011;
  localparam logic [6:0] OPC_I   = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUI = 7'b0010111;
  localparam logic [6:0] OPC_LD  = 7'b0000011;  // Load opcode, illegal in this stage

  // One expected output event
  typedef struct packed {
    logic        trap;
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_t;

  logic                      clk;
  logic                      i_reset;
  logic                      i_valid;
  logic [`EXU_INSTR_W-1:0]   i_instr;
  logic [`EXU_PC_W-1:0]      i_pc;
  logic                      o_wbck_ena;
  logic [`EXU_RFIDX_W-1:0]   o_wbck_rdidx;
  logic [`EXU_XLEN-1:0]      o_wbck_wdat;
  logic                      o_commit_trap;
  logic [`EXU_INSTRET_W-1:0] o_instret;
  logic                      o_active;

  logic [31:0] model_rf [32];  // Architectural view of the register file
  exp_t        exp_q [$];
  integer      seed;
  int          legal_sent;
  string       test_name;
  logic [31:0] pc;

  exu_top dut0 (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_instr       (i_instr),
    .i_pc          (i_pc),
    .o_wbck_ena    (o_wbck_ena),
    .o_wbck_rdidx  (o_wbck_rdidx),
    .o_wbck_wdat   (o_wbck_wdat),
    .o_commit_trap (o_commit_trap),
    .o_instret     (o_instret),
    .o_active      (o_active)
  );

  bind exu_top exu_asserts u_asserts (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_wbck_ena    (o_wbck_ena),
    .i_wbck_rdidx  (o_wbck_rdidx),
    .i_commit_trap (o_commit_trap),
    .i_instret     (o_instret),
    .i_active      (o_active)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reporting
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED: %s %s expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  //////////////////////////////
  // Encoders and reference model
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_I};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // RV32I integer semantics by funct3
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exp_t ref_exec(input logic [31:0] ins, input logic [31:0] ipc);
    exp_t        e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] imm;
    f3     = ins[14:12];
    f7     = ins[31:25];
    a      = model_rf[ins[19:15]];
    imm    = {{20{ins[31]}}, ins[31:20]};
    e.trap = 1'b0;
    e.rd   = ins[11:7];
    e.data = '0;
    case (ins[6:0])
      OPC_R: begin
        e.trap = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5)));
        e.data = alu_ref(f3, f7[5], a, model_rf[ins[24:20]]);
      end
      OPC_I: begin
        if (f3 == 3'd1) begin
          e.trap = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          e.trap = !((f7 == 7'h00) || (f7 == 7'h20));
        end
        e.data = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm);
      end
      OPC_LUI: e.data = {ins[31:12], 12'b0};
      OPC_AUI: e.data = ipc + {ins[31:12], 12'b0};
      default: e.trap = 1'b1;
    endcase
    if (!e.trap && (e.rd != 5'd0)) begin
      model_rf[e.rd] = e.data;
    end
    return e;
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [4:0] pick_reg(input logic [31:0] v, input int span);
    return 5'd1 + 5'(v % span);  // x1 up to x(span)
  endfunction

  //////////////////////////////
  // Stimulus
  task automatic issue(input logic [31:0] ins);
    exp_t e;
    @(posedge clk);
    #1;
    e       = ref_exec(ins, pc);
    i_valid = 1'b1;
    i_instr = ins;
    i_pc    = pc;
    pc      = pc + 32'd4;
    if (e.trap || (e.rd != 5'd0)) begin
      exp_q.push_back(e);  // rd = 0 gives no output event
    end
    if (!e.trap) begin
      legal_sent++;
    end
  endtask

  // Stop issuing and wait until every expected event is seen
  task automatic drain();
    int n;
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    n = 0;
    while (((exp_q.size() != 0) || o_active) && (n < 20)) begin
      @(posedge clk);
      #2;
      n++;
    end
    if ((exp_q.size() != 0) || o_active) begin
      abort_run($sformatf("Timeout in %s: %0d expected results never came out",
                          test_name, exp_q.size()));
    end
  endtask

  //////////////////////////////
  // Compare
  always @(negedge clk) begin
    exp_t e;
    if (!i_reset && (o_wbck_ena || o_commit_trap)) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("In %s the DUT produced a result nobody asked for", test_name));
      end else begin
        e = exp_q.pop_front();
        check("trap flag", e.trap, o_commit_trap);
        if (!e.trap) begin
          check("rd index", e.rd, o_wbck_rdidx);
          check("write data", e.data, o_wbck_wdat);
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    seed       = 32'h8075;
    clk        = 1'b0;
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_pc       = '0;
    pc         = 32'h0000_1000;
    legal_sent = 0;
    test_name  = "reset";
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    i_reset = 1'b0;
    check("instret", 32'd0, o_instret);

    // Every register reads zero after reset
    test_name = "zero_regs";
    for (int i = 1; i < 32; i++) begin
      issue(enc_r(7'h00, 5'd0, 5'(i), 3'd6, 5'(i)));  // OR xi, xi, x0
    end
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    drain();

    test_name = "alu_ops";
    for (int i = 1; i < 9; i++) begin
      r = rand_word();
      issue(enc_u(r[31:12], 5'(i), OPC_LUI));
      issue(enc_i(r[11:0], 5'(i), 3'd0, 5'(i)));
    end
    issue(enc_u(20'h80000, 5'd9, OPC_LUI));      // Negative source for SRA
    issue(enc_i(12'h7f5, 5'd9, 3'd6, 5'd9));
    issue(enc_r(7'h20, 5'd1, 5'd9, 3'd5, 5'd12));
    issue(enc_i(12'h41f, 5'd9, 3'd5, 5'd13));   // SRAI by 31
    issue(enc_r(7'h00, 5'd1, 5'd9, 3'd2, 5'd14));
    issue(enc_r(7'h00, 5'd1, 5'd9, 3'd3, 5'd15));
    for (int n = 0; n < 80; n++) begin
      r   = rand_word();
      f3  = r[2:0];
      alt = r[3] && ((f3 == 3'd0) || (f3 == 3'd5));
      imm = r[31:20];
      if (r[4]) begin
        issue(enc_r(alt ? 7'h20 : 7'h00, pick_reg(rand_word(), 9), pick_reg(rand_word(), 9),
                    f3, pick_reg(rand_word(), 15)));
      end else begin
        if (f3 == 3'd1) begin
          imm[11:5] = 7'h00;
        end
        if (f3 == 3'd5) begin
          imm[11:5] = r[3] ? 7'h20 : 7'h00;
        end
        issue(enc_i(imm, pick_reg(rand_word(), 9), f3, pick_reg(rand_word(), 15)));
      end
    end
    drain();

    // Each result feeds the very next instruction
    test_name = "bypass_chain";
    issue(enc_i(12'h123, 5'd0, 3'd0, 5'd20));
    for (int n = 0; n < 12; n++) begin
      issue(enc_r(7'h00, 5'(1 + n % 8), 5'd20, 3'd0, 5'd21));  // rs1 bypass
      issue(enc_r(7'h00, 5'd21, 5'(1 + n % 8), 3'd4, 5'd20));  // rs2 bypass
      issue(enc_i(12'h003, 5'd20, 3'd1, 5'd20));
    end
    drain();

    test_name = "x0_auipc";
    issue(enc_i(12'h055, 5'd1, 3'd0, 5'd0));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd22));
    issue(enc_u(20'habcde, 5'd0, OPC_LUI));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd23));
    issue(enc_u(20'h12345, 5'd24, OPC_AUI));
    issue(enc_u(20'hfffff, 5'd25, OPC_AUI));
    drain();

    test_name = "illegal";
    r = legal_sent;
    issue({12'h004, 5'd1, 3'd2, 5'd26, OPC_LD});
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd26));  // MUL encoding
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'd7, 5'd26));
    issue(enc_i(12'h401, 5'd1, 3'd1, 5'd26));
    issue(32'h0000_0000);
    issue(enc_r(7'h00, 5'd0, 5'd26, 3'd0, 5'd27));  // x26 still unchanged
    drain();
    check("instret over illegal", r + 32'd1, o_instret);

    test_name = "final";
    check("instret total", legal_sent, o_instret);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
